// ==== src/hl2link_pkg.sv ====
package hl2link_pkg;

  // one command word on the bus and on the link.
  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
  } cmd_t;

  typedef enum logic [1:0] {
    kind_sync  = 2'b00,
    kind_cmd   = 2'b01,
    kind_cl1on = 2'b10
  } frame_kind_e;

  // kind rides in the old tuser position, above the payload.
  typedef struct packed {
    frame_kind_e kind;
    cmd_t        payload;
  } frame_t;

  localparam int FRAME_SYMS = $bits(frame_t) / 2;  // 2-bit symbols per frame.

  localparam logic [1:0] START_SYM = 2'b11;
  localparam logic [1:0] IDLE_SYM  = 2'b00;

  localparam logic [5:0]  CTRL_ADDR  = 6'h39;
  localparam logic [31:0] CL1ON_DATA = 32'h1000_0000;

  typedef enum logic [2:0] {
    cmd_idle,
    cmd_mst0,
    cmd_mst1,
    cmd_slv0,
    cmd_clk1on0,
    cmd_clk1on1
  } cmd_state_e;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_shift
  } tx_state_e;

endpackage

// ==== src/link_tx.sv ====
`timescale 1ns/1ps

module link_tx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                frame_valid,
  input  hl2link_pkg::frame_t frame,
  output logic                frame_ready,
  output logic                frame_done,
  output logic [1:0]          lanes
);
  import hl2link_pkg::*;

  localparam int FRAME_W = $bits(frame_t);
  localparam int CNT_W   = $clog2(FRAME_SYMS + 1);

  tx_state_e          state;
  logic [FRAME_W-1:0] sreg;
  logic [CNT_W-1:0]   sym_cnt;

  assign frame_ready = (state == tx_idle);  // buffer empty.

  // frame buffer doubles as the shift register.
  always_ff @(posedge clk) begin
    if (frame_valid && frame_ready) begin
      sreg <= frame;
    end else if (state != tx_idle) begin
      sreg <= {sreg[FRAME_W-3:0], IDLE_SYM};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= tx_idle;
      sym_cnt    <= '0;
      lanes      <= IDLE_SYM;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        tx_idle: begin
          if (frame_valid) begin
            lanes <= START_SYM;
            state <= tx_start;
          end
        end
        tx_start: begin
          lanes   <= sreg[FRAME_W-1 -: 2];  // symbol 1.
          sym_cnt <= CNT_W'(1);
          state   <= tx_shift;
        end
        tx_shift: begin
          if (sym_cnt == CNT_W'(FRAME_SYMS)) begin
            lanes      <= IDLE_SYM;
            frame_done <= 1'b1;
            state      <= tx_idle;
          end else begin
            lanes   <= sreg[FRAME_W-1 -: 2];
            sym_cnt <= sym_cnt + 1'b1;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // no second frame gets in before the first one has fully left.
  a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
    frame_valid && frame_ready |-> ##(FRAME_SYMS + 2) (frame_done && frame_ready))
    else $error("[ERROR] link_tx frame accepted while busy, state=%0h", state);

endmodule

// ==== src/link_rx.sv ====
`timescale 1ns/1ps

module link_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [1:0]          lanes,
  output hl2link_pkg::frame_t frame,
  output logic                frame_done
);
  import hl2link_pkg::*;

  localparam int FRAME_W = $bits(frame_t);
  localparam int CNT_W   = $clog2(FRAME_SYMS);

  logic [1:0]         lanes_q;
  logic               busy;
  logic               last_sym;
  logic [CNT_W-1:0]   sym_cnt;
  logic [FRAME_W-3:0] sreg;  // first 19 symbols.

  assign last_sym = busy && (sym_cnt == CNT_W'(FRAME_SYMS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lanes_q    <= IDLE_SYM;
      busy       <= 1'b0;
      sym_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      lanes_q    <= lanes;
      frame_done <= 1'b0;
      if (!busy) begin
        // marker only counts between frames.
        if (lanes_q == START_SYM) begin
          busy    <= 1'b1;
          sym_cnt <= '0;
        end
      end else if (last_sym) begin
        busy       <= 1'b0;
        frame_done <= 1'b1;
      end else begin
        sym_cnt <= sym_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      sreg <= {sreg[FRAME_W-5:0], lanes_q};
    end
    if (last_sym) begin
      frame <= frame_t'({sreg, lanes_q});
    end
  end

endmodule

// ==== src/hl2link.sv ====
`timescale 1ns/1ps

module hl2link #(
  parameter int SYNC_INTERVAL = 64,
  parameter int LOSS_LIMIT    = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                phy_connected,
  input  logic                master_sel,
  input  logic [1:0]          linkrx,
  output logic [1:0]          linktx,
  output logic                running,
  input  logic                send_valid,
  input  hl2link_pkg::frame_t send_frame,
  output logic                send_ready,
  output logic                send_done,
  output hl2link_pkg::frame_t recv_frame,
  output logic                recv_done,
  output logic                cl1on_rqst,
  input  logic                cl1on_ack
);
  import hl2link_pkg::*;

  localparam int LOSS_CYCLES = LOSS_LIMIT * SYNC_INTERVAL;
  localparam int SYNC_W      = $clog2(SYNC_INTERVAL);
  localparam int LOSS_W      = $clog2(LOSS_CYCLES);

  logic [SYNC_W-1:0] sync_cnt;
  logic [LOSS_W-1:0] loss_cnt;
  logic              sync_tick, sync_pend, cl1on_pend, running_q;
  logic              loss_expired;
  logic              local_valid, local_take;
  logic              tx_valid, tx_ready, tx_done;
  logic              rx_done;
  frame_t            tx_frame, local_frame, rx_frame;

  assign sync_tick    = (sync_cnt == SYNC_W'(SYNC_INTERVAL - 1));
  assign loss_expired = (loss_cnt == LOSS_W'(LOSS_CYCLES - 1)) && !rx_done;

  // app frames win; local ones go only when nothing is waiting.
  assign local_valid = sync_pend | cl1on_pend;
  assign local_take  = local_valid && !send_valid && tx_ready;
  assign local_frame = cl1on_pend ?
                       '{kind: kind_cl1on, payload: '{addr: CTRL_ADDR, data: CL1ON_DATA}} :
                       '{kind: kind_sync, payload: '0};

  assign tx_valid   = send_valid | local_valid;
  assign tx_frame   = send_valid ? send_frame : local_frame;
  assign send_ready = tx_ready;
  assign send_done  = tx_done;

  assign recv_frame = rx_frame;
  assign recv_done  = rx_done && (rx_frame.kind == kind_cmd);  // sync and cl1on end here.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_cnt   <= '0;
      sync_pend  <= 1'b0;
      cl1on_pend <= 1'b0;
      running_q  <= 1'b0;
    end else begin
      sync_cnt  <= sync_tick ? '0 : sync_cnt + 1'b1;
      running_q <= running;
      if (local_take && !cl1on_pend) sync_pend <= 1'b0;
      if (sync_tick) sync_pend <= 1'b1;
      if (local_take && cl1on_pend) cl1on_pend <= 1'b0;
      if (running && !running_q && master_sel) cl1on_pend <= 1'b1;  // master wakes the peer.
      if (!phy_connected) begin
        sync_pend  <= 1'b0;
        cl1on_pend <= 1'b0;
      end
    end
  end

  // link health from received traffic.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      loss_cnt   <= '0;
      running    <= 1'b0;
      cl1on_rqst <= 1'b0;
    end else begin
      if (rx_done) begin
        loss_cnt <= '0;
      end else if (loss_cnt != LOSS_W'(LOSS_CYCLES - 1)) begin
        loss_cnt <= loss_cnt + 1'b1;
      end
      if (!phy_connected) begin
        running <= 1'b0;
      end else if (rx_done && rx_frame.kind == kind_sync) begin
        running <= 1'b1;
      end else if (loss_expired) begin
        running <= 1'b0;
      end
      if (cl1on_rqst && cl1on_ack) begin
        cl1on_rqst <= 1'b0;
      end else if (rx_done && rx_frame.kind == kind_cl1on) begin
        cl1on_rqst <= 1'b1;
      end
    end
  end

  link_tx link_tx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame_valid(tx_valid),
    .frame      (tx_frame),
    .frame_ready(tx_ready),
    .frame_done (tx_done),
    .lanes      (linktx)
  );

  link_rx link_rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .lanes     (linkrx),
    .frame     (rx_frame),
    .frame_done(rx_done)
  );

  // request is held until the app has acknowledged it.
  a_cl1on_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cl1on_rqst) |-> $past(cl1on_ack))
    else $error("[ERROR] cl1on_rqst fell without cl1on_ack, ack=%0h", cl1on_ack);

endmodule

// ==== src/hl2link_app.sv ====
`timescale 1ns/1ps

module hl2link_app #(
  parameter int SYNC_INTERVAL = 64,
  parameter int LOSS_LIMIT    = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              phy_connected,
  input  logic [1:0]        linkrx,
  output logic [1:0]        linktx,
  output logic              running,
  input  hl2link_pkg::cmd_t ds_cmd,
  input  logic              ds_cmd_rqst,
  input  logic              ds_cmd_resprqst,
  input  logic              ds_cmd_is_alt,
  output hl2link_pkg::cmd_t cmd,
  output logic              cmd_cnt,
  output logic              cmd_resprqst,
  output logic              cmd_is_alt
);
  import hl2link_pkg::*;

  cmd_state_e state, state_next;
  cmd_t       cmd_next;
  logic       cmd_cnt_next;
  logic       cmd_resprqst_next;
  logic       cmd_is_alt_next;
  logic       ds_take;
  logic       master_sel;

  logic       send_valid, send_ready, send_done;
  frame_t     send_frame, recv_frame;
  logic       recv_done;
  logic       cl1on_rqst, cl1on_ack;

  assign send_frame = '{kind: kind_cmd, payload: cmd};  // cmd already holds the new word.

  // link control register, bit 31 picks master.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      master_sel <= 1'b0;
    end else if (ds_take && ds_cmd.addr == CTRL_ADDR) begin
      master_sel <= ds_cmd.data[31];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= cmd_idle;
      cmd_cnt <= 1'b0;
    end else begin
      state   <= state_next;
      cmd_cnt <= cmd_cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    cmd          <= cmd_next;
    cmd_resprqst <= cmd_resprqst_next;
    cmd_is_alt   <= cmd_is_alt_next;
  end

  always_comb begin
    state_next        = state;
    cmd_next          = cmd;
    cmd_cnt_next      = cmd_cnt;
    cmd_resprqst_next = cmd_resprqst;
    cmd_is_alt_next   = cmd_is_alt;
    ds_take           = 1'b0;
    send_valid        = 1'b0;
    cl1on_ack         = 1'b0;

    case (state)
      cmd_idle: begin
        if (recv_done) begin
          state_next = cmd_slv0;
        end else if (cl1on_rqst) begin
          state_next = cmd_clk1on0;
        end else if (ds_cmd_rqst) begin
          ds_take           = 1'b1;
          cmd_next          = ds_cmd;
          cmd_resprqst_next = ds_cmd_resprqst;
          cmd_is_alt_next   = ds_cmd_is_alt;
          state_next        = running ? cmd_mst0 : cmd_mst1;
        end
      end
      cmd_mst0: begin
        send_valid = 1'b1;  // hold until the tx buffer takes it.
        if (send_ready || send_done) state_next = cmd_mst1;
      end
      cmd_mst1: begin
        cmd_cnt_next = ~cmd_cnt;
        state_next   = cmd_idle;
      end
      cmd_slv0: begin
        cmd_next          = recv_frame.payload;
        cmd_resprqst_next = 1'b0;
        cmd_is_alt_next   = 1'b0;
        cmd_cnt_next      = ~cmd_cnt;
        state_next        = cmd_idle;
      end
      cmd_clk1on0: begin
        // synthetic write that turns the clock on.
        cmd_next.addr     = CTRL_ADDR;
        cmd_next.data     = CL1ON_DATA;
        cmd_resprqst_next = 1'b0;
        cmd_is_alt_next   = 1'b0;
        cmd_cnt_next      = ~cmd_cnt;
        state_next        = cmd_clk1on1;
      end
      cmd_clk1on1: begin
        cl1on_ack = 1'b1;
        if (!cl1on_rqst) state_next = cmd_idle;
      end
      default: state_next = cmd_idle;
    endcase
  end

  hl2link #(
    .SYNC_INTERVAL(SYNC_INTERVAL),
    .LOSS_LIMIT   (LOSS_LIMIT)
  ) hl2link_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .phy_connected(phy_connected),
    .master_sel   (master_sel),
    .linkrx       (linkrx),
    .linktx       (linktx),
    .running      (running),
    .send_valid   (send_valid),
    .send_frame   (send_frame),
    .send_ready   (send_ready),
    .send_done    (send_done),
    .recv_frame   (recv_frame),
    .recv_done    (recv_done),
    .cl1on_rqst   (cl1on_rqst),
    .cl1on_ack    (cl1on_ack)
  );

  // bus strobe only moves from the three issuing states.
  a_cmd_cnt_state: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(cmd_cnt) |-> $past(state) inside {cmd_mst1, cmd_slv0, cmd_clk1on0})
    else $error("[ERROR] cmd_cnt changed from state %0h", $past(state));

endmodule

// ==== tests/tb_hl2link.sv ====
`timescale 1ns/1ps

module tb_hl2link;
  import hl2link_pkg::*;

  localparam int SYNC_INTERVAL = 64;
  localparam int LOSS_LIMIT    = 4;
  localparam int TEST_CYCLES   = 4000;  // rough sum of the five tests.

  logic       clk;
  logic       rst_n;
  logic       dut_phy, peer_phy;
  logic [1:0] dut_linktx, peer_linktx;
  logic       dut_running, peer_running;
  cmd_t       ds_cmd, dut_cmd, peer_cmd;
  logic       ds_cmd_rqst, ds_cmd_resprqst, ds_cmd_is_alt;
  logic       dut_cmd_cnt, dut_cmd_resprqst, dut_cmd_is_alt;
  logic       peer_cmd_cnt, peer_cmd_resprqst, peer_cmd_is_alt;

  int         seed;
  int         errors;
  int         tests_failed;
  int         peer_seen;
  logic       peer_cnt_q;
  logic       peer_must_run;
  cmd_t       peer_expect[$];
  cmd_t       peer_want;

  hl2link_app #(
    .SYNC_INTERVAL(SYNC_INTERVAL),
    .LOSS_LIMIT   (LOSS_LIMIT)
  ) hl2link_app_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .phy_connected  (dut_phy),
    .linkrx         (peer_linktx),
    .linktx         (dut_linktx),
    .running        (dut_running),
    .ds_cmd         (ds_cmd),
    .ds_cmd_rqst    (ds_cmd_rqst),
    .ds_cmd_resprqst(ds_cmd_resprqst),
    .ds_cmd_is_alt  (ds_cmd_is_alt),
    .cmd            (dut_cmd),
    .cmd_cnt        (dut_cmd_cnt),
    .cmd_resprqst   (dut_cmd_resprqst),
    .cmd_is_alt     (dut_cmd_is_alt)
  );

  // far end of the link, never issues commands of its own.
  hl2link_app #(
    .SYNC_INTERVAL(SYNC_INTERVAL),
    .LOSS_LIMIT   (LOSS_LIMIT)
  ) peer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .phy_connected  (peer_phy),
    .linkrx         (dut_linktx),
    .linktx         (peer_linktx),
    .running        (peer_running),
    .ds_cmd         ('0),
    .ds_cmd_rqst    (1'b0),
    .ds_cmd_resprqst(1'b0),
    .ds_cmd_is_alt  (1'b0),
    .cmd            (peer_cmd),
    .cmd_cnt        (peer_cmd_cnt),
    .cmd_resprqst   (peer_cmd_resprqst),
    .cmd_is_alt     (peer_cmd_is_alt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (5 * TEST_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is stuck", 5 * TEST_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // both phys down means a silent link.
  a_quiet_link: assert property (@(posedge clk) disable iff (!rst_n)
    !dut_phy && !peer_phy |->
      !dut_running && !peer_running && dut_linktx == 2'b00 && peer_linktx == 2'b00)
    else begin
      errors = errors + 1;
      $display("[ERROR] running dut/peer: got %h/%h expected 0/0",
               dut_running, peer_running);
      $display("[ERROR] linktx dut/peer: got %h/%h expected 0/0",
               dut_linktx, peer_linktx);
    end

  a_dut_drop: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(dut_phy) |=> !dut_running)
    else begin
      errors = errors + 1;
      $display("[ERROR] dut running: got %h expected %h", dut_running, 1'b0);
    end

  a_peer_run: assert property (@(posedge clk) disable iff (!rst_n)
    peer_must_run |-> peer_running)
    else begin
      errors = errors + 1;
      $display("[ERROR] peer running: got %h expected %h", peer_running, 1'b1);
    end

  // peer bus monitor, commands must come out in send order.
  always @(negedge clk) begin
    if (rst_n && peer_cmd_cnt !== peer_cnt_q) begin
      peer_seen = peer_seen + 1;
      assert (peer_expect.size() > 0) else begin
        errors = errors + 1;
        $display("peer put a command on its bus that the DUT never sent");
      end
      if (peer_expect.size() > 0) begin
        peer_want = peer_expect.pop_front();
        assert (peer_cmd == peer_want) else begin
          errors = errors + 1;
          $display("[ERROR] peer cmd: got %h expected %h", peer_cmd, peer_want);
        end
        assert (!peer_cmd_resprqst && !peer_cmd_is_alt) else begin
          errors = errors + 1;
          $display("[ERROR] peer cmd_resprqst/cmd_is_alt: got %h/%h expected 0/0",
                   peer_cmd_resprqst, peer_cmd_is_alt);
        end
      end
    end
    peer_cnt_q = peer_cmd_cnt;
  end

  function automatic cmd_t random_cmd();
    cmd_t c;
    c.addr = 6'($random(seed));
    c.data = $random(seed);
    if (c.addr == CTRL_ADDR) begin
      c.addr = 6'h3a;  // stay off the control register.
    end
    return c;
  endfunction

  // called on a falling edge; returns on the edge that shows the toggle.
  task automatic issue_cmd(input cmd_t c, input logic resp, input logic alt,
                           input logic forward, input int want_cycles);
    logic cnt_before;
    int   cycles;
    cnt_before      = dut_cmd_cnt;
    cycles          = 0;
    ds_cmd          = c;
    ds_cmd_resprqst = resp;
    ds_cmd_is_alt   = alt;
    ds_cmd_rqst     = 1'b1;
    if (forward) begin
      peer_expect.push_back(c);
    end
    while (dut_cmd_cnt == cnt_before && cycles < SYNC_INTERVAL) begin
      @(negedge clk);
      cycles++;
    end
    ds_cmd_rqst = 1'b0;
    assert (dut_cmd_cnt != cnt_before) else begin
      errors = errors + 1;
      $display("DUT cmd_cnt did not toggle within %0d cycles of a request", SYNC_INTERVAL);
    end
    if (want_cycles > 0) begin
      assert (cycles == want_cycles) else begin
        errors = errors + 1;
        $display("[ERROR] cmd_cnt latency: got %h expected %h", cycles, want_cycles);
      end
    end
    assert (dut_cmd == c && dut_cmd_resprqst == resp && dut_cmd_is_alt == alt) else begin
      errors = errors + 1;
      $display("[ERROR] cmd/resprqst/is_alt: got %h/%h/%h expected %h/%h/%h",
               dut_cmd, dut_cmd_resprqst, dut_cmd_is_alt, c, resp, alt);
    end
  endtask

  task automatic wait_peer(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (peer_seen < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    assert (peer_seen == target && peer_expect.size() == 0) else begin
      errors = errors + 1;
      $display("peer showed %0d commands where %0d were due within %0d cycles",
               peer_seen, target, limit);
    end
    @(negedge clk);
  endtask

  task automatic close_test(input int num, input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d check(s) failed", num, name, errors - errs_at_start);
    end
  endtask

  initial begin
    int   mark;
    int   cycles;
    cmd_t c;
    seed            = 32'hd0eb;
    errors          = 0;
    tests_failed    = 0;
    peer_seen       = 0;
    peer_must_run   = 1'b0;
    rst_n           = 1'b0;
    dut_phy         = 1'b0;
    peer_phy        = 1'b0;
    ds_cmd          = '0;
    ds_cmd_rqst     = 1'b0;
    ds_cmd_resprqst = 1'b0;
    ds_cmd_is_alt   = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    mark = errors;
    assert (!dut_cmd_cnt && !peer_cmd_cnt) else begin
      errors = errors + 1;
      $display("[ERROR] cmd_cnt dut/peer: got %h/%h expected 0/0", dut_cmd_cnt, peer_cmd_cnt);
    end
    issue_cmd(random_cmd(), 1'($random(seed)), 1'($random(seed)), 1'b0, 2);
    repeat (8) @(negedge clk);
    assert (peer_seen == 0) else begin
      errors = errors + 1;
      $display("peer bus moved while the link was down");
    end
    close_test(1, "link down", mark);

    mark     = errors;
    dut_phy  = 1'b1;
    peer_phy = 1'b1;
    cycles   = 0;
    while (!(dut_running && peer_running) && cycles < 3 * SYNC_INTERVAL) begin
      @(negedge clk);
      cycles++;
    end
    assert (dut_running && peer_running) else begin
      errors = errors + 1;
      $display("running did not rise on both ends within %0d cycles", 3 * SYNC_INTERVAL);
    end
    peer_must_run = 1'b1;
    close_test(2, "link up", mark);

    mark = errors;
    for (int i = 0; i < 8; i++) begin
      issue_cmd(random_cmd(), 1'($random(seed)), 1'($random(seed)), 1'b1, 0);
    end
    wait_peer(8, 16 * SYNC_INTERVAL);
    close_test(3, "commands to peer", mark);

    mark = errors;
    c = random_cmd();
    c.addr     = CTRL_ADDR;
    c.data[31] = 1'b1;  // this end becomes master.
    issue_cmd(c, 1'b0, 1'b0, 1'b1, 0);
    wait_peer(9, 2 * SYNC_INTERVAL);
    dut_phy = 1'b0;
    repeat (4) @(negedge clk);
    c = '{addr: CTRL_ADDR, data: CL1ON_DATA};
    peer_expect.push_back(c);
    dut_phy = 1'b1;
    wait_peer(10, 4 * SYNC_INTERVAL);
    close_test(4, "master wakes peer", mark);

    mark          = errors;
    peer_must_run = 1'b0;
    dut_phy       = 1'b0;
    @(negedge clk);
    cycles = 1;
    while (peer_running && cycles < LOSS_LIMIT * SYNC_INTERVAL + 32) begin
      @(negedge clk);
      cycles++;
    end
    assert (!peer_running) else begin
      errors = errors + 1;
      $display("peer kept running %0d cycles after the DUT went silent", cycles);
    end
    close_test(5, "link loss", mark);

    $display("5 tests run, %0d failed, %0d check errors", tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/hl2link_pkg.sv
src/link_tx.sv
src/link_rx.sv
src/hl2link.sv
src/hl2link_app.sv
tests/tb_hl2link.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the hl2link testbench with Verilator and run it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_hl2link -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_hl2link)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
